/* common/pce_media_settings.svh */
// Constants for ROM header detection and backup RAM layout, included by the users
`ifndef PCE_MEDIA_SETTINGS_SVH
`define PCE_MEDIA_SETTINGS_SVH

// ==================================================
// Backup RAM geometry
// ==================================================
`define PCE_BRAM_SECTORS   16     // Sectors moved per load or save
`define PCE_SECTOR_WORDS   256    // 16-bit words in a 512-byte sector

// Title header lines, in 16-byte units
`define PCE_HDR_BANK0_ADDR 20'h1f2
`define PCE_HDR_BANK1_ADDR 20'h212

// Populous signature at header offsets 6, 8, 10 and 12
`define PCE_POP_SIG0       16'h4f50
`define PCE_POP_SIG1       16'h5550
`define PCE_POP_SIG2       16'h4f4c
`define PCE_POP_SIG3       16'h5355

// Download index low bits of a SuperGrafx image
`define PCE_SGX_INDEX      5'd2

// Format defaults, "HUBM" tag then the free pointer
`define PCE_FMT_WORD0      16'h5548
`define PCE_FMT_WORD1      16'h4d42
`define PCE_FMT_WORD2      16'h8800
`define PCE_FMT_WORD3      16'h8010

`endif

/* common/pce_media_pkg.sv */
// Bus and record types shared by the media blocks, imported where a block needs them
`default_nettype none

package pce_media_pkg;

	// ==================================================
	// Host download bus
	// ==================================================
	typedef struct packed {
		logic        download;  // Transfer in progress
		logic [7:0]  index;     // Menu slot of the file
		logic        wr;        // Word strobe
		logic [24:0] addr;      // Byte address
		logic [15:0] data;
	} ioctl_t;

	// Menu levels this block cares about
	typedef struct packed {
		logic rom_swap;
		logic bk_load;
		logic bk_save;
		logic autosave;
		logic format;
		logic osd_open;         // OSD shown
	} menu_ctrl_t;

	// One cheat record, words are big endian as delivered
	typedef struct packed {
		logic        load;      // Single-cycle strobe
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// SD host side of the sector buffer
	typedef struct packed {
		logic        ack;
		logic [7:0]  buff_addr;
		logic [15:0] buff_dout;  // Host to core
		logic        buff_wr;
	} sd_sector_t;

endpackage

`default_nettype wire

/* source/cart_loader.sv */
// ROM download sequencer: optional bit swap, toggle writes to the ROM store, header checks
`timescale 1ns/1ps
`default_nettype none

`include "pce_media_settings.svh"

module cart_loader (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire                        cart_download,
	input  wire pce_media_pkg::ioctl_t ioctl,
	input  wire                        rom_swap,
	input  wire                        rom_wr_ack,
	output logic                       ioctl_wait,
	output logic                       rom_wr,
	output logic [23:0]                rom_addr,
	output logic [15:0]                rom_data,
	output logic [1:0]                 populous,
	output logic                       sgx
);

	logic        download_d;
	logic        dl_start;
	logic [15:0] data_rev;
	logic        hdr_line;
	logic        sig_bad;

	// ==================================================
	// Data path
	// ==================================================
	always_comb begin
		for (int i = 0; i < 16; i++) begin
			data_rev[i] = ioctl.data[15 - i];
		end
	end

	assign rom_data = rom_swap ? data_rev : ioctl.data;

	assign dl_start = cart_download & ~download_d;

	// Either bank's title line
	assign hdr_line = (rom_addr[23:4] == `PCE_HDR_BANK0_ADDR) ||
	                  (rom_addr[23:4] == `PCE_HDR_BANK1_ADDR);

	always_comb begin
		case (rom_addr[3:0])
			4'd6:    sig_bad = (rom_data != `PCE_POP_SIG0);
			4'd8:    sig_bad = (rom_data != `PCE_POP_SIG1);
			4'd10:   sig_bad = (rom_data != `PCE_POP_SIG2);
			4'd12:   sig_bad = (rom_data != `PCE_POP_SIG3);
			default: sig_bad = 1'b0;  // Not a signature word
		endcase
	end

	// ==================================================
	// Write sequencer
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_d <= 1'b0;
			ioctl_wait <= 1'b0;
			rom_wr     <= 1'b0;
			rom_addr   <= '0;
			populous   <= 2'b00;
			sgx        <= 1'b0;
		end else begin
			download_d <= cart_download;
			if (dl_start) begin
				rom_addr <= '0;
				populous <= 2'b11;  // Assume both banks until a word disagrees
				sgx      <= (ioctl.index[4:0] == `PCE_SGX_INDEX);
			end else if (ioctl.wr && cart_download) begin
				ioctl_wait <= 1'b1;
				rom_wr     <= ~rom_wr;     // New request to the store
				if (hdr_line && sig_bad)
					populous[rom_addr[13]] <= 1'b0;
			end else if (ioctl_wait && (rom_wr == rom_wr_ack)) begin
				ioctl_wait <= 1'b0;
				rom_addr   <= rom_addr + 24'd2;
			end
		end
	end

endmodule

`default_nettype wire

/* source/cheat_code_assembler.sv */
// Collects eight download words into one cheat record and strobes it out
`timescale 1ns/1ps
`default_nettype none

module cheat_code_assembler (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire                        code_download,
	input  wire pce_media_pkg::ioctl_t ioctl,
	output pce_media_pkg::cheat_code_t cheat
);

	logic code_wr;

	assign code_wr = code_download & ioctl.wr;

	// Fields keep their value until overwritten, only the strobe is cleared
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat.load <= 1'b0;
		end else begin
			cheat.load <= 1'b0;
			if (code_wr) begin
				case (ioctl.addr[3:0])
					4'd0:  cheat.flags[15:0]    <= ioctl.data;
					4'd2:  cheat.flags[31:16]   <= ioctl.data;
					4'd4:  cheat.addr[15:0]     <= ioctl.data;
					4'd6:  cheat.addr[31:16]    <= ioctl.data;
					4'd8:  cheat.compare[15:0]  <= ioctl.data;
					4'd10: cheat.compare[31:16] <= ioctl.data;
					4'd12: cheat.replace[15:0]  <= ioctl.data;
					4'd14: begin
						cheat.replace[31:16] <= ioctl.data;
						cheat.load           <= 1'b1;  // Record complete
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* backup/backup_ram.sv */
// Backup RAM: two byte lanes, console port A and SD sector buffer port B, plus format writer
`timescale 1ns/1ps
`default_nettype none

`include "pce_media_settings.svh"

module backup_ram (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire [10:0]                     bram_addr,
	input  wire [7:0]                      bram_data,
	input  wire                            bram_wr,
	input  wire [3:0]                      sd_lba_low,
	input  wire pce_media_pkg::sd_sector_t sd,
	input  wire                            format,
	output logic [7:0]                     bram_q,
	output logic [15:0]                    sd_buff_din,
	output logic                           fmt_busy
);

	localparam int LANE_DEPTH = `PCE_BRAM_SECTORS * `PCE_SECTOR_WORDS;

	logic            format_d;
	logic [3:0]      fmt_cnt;     // Bit 3 set when idle
	logic [15:0]     fmt_word;
	logic [11:0]     addr_a;
	logic [11:0]     addr_b;
	logic [15:0]     data_b;
	logic            wr_b;
	logic            lane_sel_q;
	logic [1:0][7:0] q_a;
	logic [1:0][7:0] q_b;

	// ==================================================
	// Format writer
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			format_d <= 1'b0;
			fmt_cnt  <= 4'h8;
		end else begin
			format_d <= format;
			if (format && !format_d)
				fmt_cnt <= 4'h0;
			else if (!fmt_cnt[3])
				fmt_cnt <= fmt_cnt + 4'd1;
		end
	end

	assign fmt_busy = ~fmt_cnt[3];

	always_comb begin
		case (fmt_cnt[2:1])
			2'd0:    fmt_word = `PCE_FMT_WORD0;
			2'd1:    fmt_word = `PCE_FMT_WORD1;
			2'd2:    fmt_word = `PCE_FMT_WORD2;
			default: fmt_word = `PCE_FMT_WORD3;
		endcase
	end

	// Port B belongs to the format writer while it runs
	assign addr_a = {2'b00, bram_addr[10:1]};
	assign addr_b = fmt_busy ? {10'd0, fmt_cnt[2:1]} : {sd_lba_low, sd.buff_addr};
	assign data_b = fmt_busy ? fmt_word : sd.buff_dout;
	assign wr_b   = fmt_busy ? fmt_cnt[0] : (sd.buff_wr & sd.ack);

	// ==================================================
	// Byte lanes, lane 0 holds even console bytes
	// ==================================================
	for (genvar i = 0; i < 2; i++) begin : g_lane
		logic [7:0] mem [LANE_DEPTH];

		always_ff @(posedge clk_sys) begin
			if (bram_wr && (bram_addr[0] == i[0]))
				mem[addr_a] <= bram_data;
			if (wr_b)
				mem[addr_b] <= data_b[8*i +: 8];
			q_a[i] <= mem[addr_a];
			q_b[i] <= mem[addr_b];
		end
	end

	always_ff @(posedge clk_sys) begin
		lane_sel_q <= bram_addr[0];
	end

	assign bram_q      = lane_sel_q ? q_a[1] : q_a[0];
	assign sd_buff_din = {q_b[1], q_b[0]};

endmodule

`default_nettype wire

/* backup/backup_sector_ctrl.sv */
// Backup enable, autosave tracking and the SD sector sequencer for load and save
`timescale 1ns/1ps
`default_nettype none

`include "pce_media_settings.svh"

module backup_sector_ctrl (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire                            cart_download,
	input  wire pce_media_pkg::menu_ctrl_t menu,
	input  wire                            bram_wr,
	input  wire                            img_mounted,
	input  wire                            img_readonly,
	input  wire                            img_present,
	input  wire                            sd_ack,
	output logic [31:0]                    sd_lba,
	output logic                           sd_rd,
	output logic                           sd_wr,
	output logic                           bk_busy,
	output logic                           bk_loading,
	output logic                           bk_pending
);

	localparam logic [3:0] LAST_SECTOR = 4'(`PCE_BRAM_SECTORS - 1);

	logic bk_ena;
	logic download_d;
	logic load_d;
	logic save_d;
	logic ack_d;
	logic save_req;
	logic load_start;
	logic save_start;
	logic boot_load;

	// Autosave only fires once the menu is opened
	assign save_req   = menu.bk_save | (bk_pending & menu.osd_open & menu.autosave);
	assign load_start = menu.bk_load & ~load_d;
	assign save_start = save_req & ~save_d;
	assign boot_load  = download_d & ~cart_download & img_present & bk_ena;

	// ==================================================
	// Enable and pending flags
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_d <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			download_d <= cart_download;
			if (cart_download && !download_d)
				bk_ena <= 1'b0;
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= 1'b1;  // Save image mounts at the end of the download

			if (bk_ena && !menu.osd_open && bram_wr)
				bk_pending <= 1'b1;
			else if (bk_busy)
				bk_pending <= 1'b0;
		end
	end

	// ==================================================
	// Sector sequencer
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_d     <= 1'b0;
			save_d     <= 1'b0;
			ack_d      <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			load_d <= menu.bk_load;
			save_d <= save_req;
			ack_d  <= sd_ack;

			if (sd_ack && !ack_d) begin
				sd_rd <= 1'b0;  // Host took the request
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (bk_ena && (load_start || save_start)) begin
					bk_busy    <= 1'b1;
					bk_loading <= menu.bk_load;
					sd_lba     <= '0;
					sd_rd      <= menu.bk_load;
					sd_wr      <= ~menu.bk_load;
				end
				if (boot_load) begin
					bk_busy    <= 1'b1;
					bk_loading <= 1'b1;
					sd_lba     <= '0;
					sd_rd      <= 1'b1;
					sd_wr      <= 1'b0;
				end
			end else if (ack_d && !sd_ack) begin
				if (sd_lba[3:0] == LAST_SECTOR) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 32'd1;  // Next sector
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* source/pce_media_top.sv */
// Cartridge-side housekeeping top: download decode, ROM loader, cheats and backup RAM
`timescale 1ns/1ps
`default_nettype none

module pce_media_top (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire pce_media_pkg::ioctl_t     ioctl,
	input  wire pce_media_pkg::menu_ctrl_t menu,
	input  wire                            rom_wr_ack,
	input  wire [10:0]                     bram_addr,
	input  wire [7:0]                      bram_data,
	input  wire                            bram_wr,
	input  wire pce_media_pkg::sd_sector_t sd,
	input  wire                            img_mounted,
	input  wire                            img_readonly,
	input  wire                            img_present,
	output logic                           ioctl_wait,
	output logic                           rom_wr,
	output logic [23:0]                    rom_addr,
	output logic [15:0]                    rom_data,
	output logic [1:0]                     populous,
	output logic                           sgx,
	output pce_media_pkg::cheat_code_t     cheat,
	output logic [7:0]                     bram_q,
	output logic [15:0]                    sd_buff_din,
	output logic [31:0]                    sd_lba,
	output logic                           sd_rd,
	output logic                           sd_wr,
	output logic                           bk_busy,
	output logic                           bk_loading,
	output logic                           bk_pending
);

	logic code_index;
	logic code_download;
	logic cart_download;

	// All-ones index carries cheat codes, everything else is a cartridge
	assign code_index    = &ioctl.index;
	assign code_download = ioctl.download & code_index;
	assign cart_download = ioctl.download & ~code_index;

	cart_loader u_cart_loader (
		.clk_sys(clk_sys), .reset(reset), .cart_download(cart_download),
		.ioctl(ioctl), .rom_swap(menu.rom_swap), .rom_wr_ack(rom_wr_ack),
		.ioctl_wait(ioctl_wait), .rom_wr(rom_wr), .rom_addr(rom_addr),
		.rom_data(rom_data), .populous(populous), .sgx(sgx)
	);

	cheat_code_assembler u_cheat (
		.clk_sys(clk_sys), .reset(reset), .code_download(code_download),
		.ioctl(ioctl), .cheat(cheat)
	);

	// Format status stays internal to the RAM
	backup_ram u_backup_ram (
		.clk_sys(clk_sys), .reset(reset), .bram_addr(bram_addr),
		.bram_data(bram_data), .bram_wr(bram_wr), .sd_lba_low(sd_lba[3:0]),
		.sd(sd), .format(menu.format), .bram_q(bram_q),
		.sd_buff_din(sd_buff_din), .fmt_busy()
	);

	backup_sector_ctrl u_sector_ctrl (
		.clk_sys(clk_sys), .reset(reset), .cart_download(cart_download),
		.menu(menu), .bram_wr(bram_wr), .img_mounted(img_mounted),
		.img_readonly(img_readonly), .img_present(img_present), .sd_ack(sd.ack),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr), .bk_busy(bk_busy),
		.bk_loading(bk_loading), .bk_pending(bk_pending)
	);

endmodule

`default_nettype wire

/* verif/tb_pce_media_top.sv */
// Random-stimulus testbench that checks pce_media_top against a model when make run builds it
`timescale 1ns/1ps
`default_nettype none

`include "pce_media_settings.svh"

module tb_pce_media_top;
	import pce_media_pkg::*;

	localparam int IMAGE_WORDS = 'h2130 / 2;  // Ends past the bank 1 header line
	localparam int WATCHDOG_CYCLES = (300 + 3 * IMAGE_WORDS) * 10 +
		3 * `PCE_BRAM_SECTORS * (`PCE_SECTOR_WORDS + 16) + 20000;

	logic        clk_sys;
	logic        reset;
	ioctl_t      ioctl;
	menu_ctrl_t  menu;
	logic        rom_wr_ack;
	logic [10:0] bram_addr;
	logic [7:0]  bram_data;
	logic        bram_wr;
	sd_sector_t  sd;
	logic        img_mounted;
	logic        img_readonly;
	logic        img_present;
	logic        ioctl_wait;
	logic        rom_wr;
	logic [23:0] rom_addr;
	logic [15:0] rom_data;
	logic [1:0]  populous;
	logic        sgx;
	cheat_code_t cheat;
	logic [7:0]  bram_q;
	logic [15:0] sd_buff_din;
	logic [31:0] sd_lba;
	logic        sd_rd;
	logic        sd_wr;
	logic        bk_busy;
	logic        bk_loading;
	logic        bk_pending;

	integer     seed = 58;
	logic [7:0] lane_mem [2][4096];  // Model of both byte lanes
	bit         known [2][4096];

	pce_media_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Result: FAILED");
		$fatal(1);
	end

	// ROM store model answers each toggle after 0 to 5 cycles
	initial begin : rom_store
		int delay;
		forever begin
			@(negedge clk_sys);
			if ((rom_wr !== rom_wr_ack) && !reset) begin
				delay = int'($unsigned($random(seed)) % 6);
				repeat (delay) @(negedge clk_sys);
				rom_wr_ack = rom_wr;
			end
		end
	end

	// ==================================================
	// Helpers
	// ==================================================
	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	function automatic logic [15:0] reverse16(input logic [15:0] w);
		logic [15:0] r;
		for (int i = 0; i < 16; i++)
			r[i] = w[15 - i];
		return r;
	endfunction

	function automatic logic [15:0] sig_word(input int n);
		case (n)
			0:       return `PCE_POP_SIG0;
			1:       return `PCE_POP_SIG1;
			2:       return `PCE_POP_SIG2;
			default: return `PCE_POP_SIG3;
		endcase
	endfunction

	function automatic logic [15:0] fmt_word(input int n);
		case (n)
			0:       return `PCE_FMT_WORD0;
			1:       return `PCE_FMT_WORD1;
			2:       return `PCE_FMT_WORD2;
			default: return `PCE_FMT_WORD3;
		endcase
	endfunction

	task automatic send_rom_word(input logic [23:0] byte_addr, input logic [15:0] raw,
		input logic swap);
		logic        prev_wr;
		logic [15:0] exp_data;
		exp_data = swap ? reverse16(raw) : raw;
		prev_wr = rom_wr;
		ioctl.addr = {1'b0, byte_addr};
		ioctl.data = raw;
		ioctl.wr = 1'b1;
		menu.rom_swap = swap;
		@(negedge clk_sys);
		ioctl.wr = 1'b0;
		check("rom_wr toggle", 32'(!prev_wr), 32'(rom_wr));
		check("rom_addr", 32'(byte_addr), 32'(rom_addr));
		check("rom_data", 32'(exp_data), 32'(rom_data));
		check("ioctl_wait set", 32'(1), 32'(ioctl_wait));
		while (rom_wr !== rom_wr_ack)
			@(negedge clk_sys);
		@(negedge clk_sys);
		check("ioctl_wait clear", 32'(0), 32'(ioctl_wait));
	endtask

	// Bank mask places the signature and bad spoils one bank 1 word
	task automatic load_image(input logic [7:0] index, input int nwords,
		input logic [1:0] sig_mask, input logic bad);
		logic [23:0] a;
		logic [15:0] raw;
		logic [15:0] exp_data;
		logic        swap;
		logic [1:0]  pop_exp;
		int          off;
		ioctl.index = index;
		ioctl.download = 1'b1;
		repeat (2) @(negedge clk_sys);
		pop_exp = 2'b11;
		for (int i = 0; i < nwords; i++) begin
			a = 24'(2 * i);
			swap = 1'($random(seed));
			raw = 16'($random(seed));
			off = int'(a[3:0]);
			if ((a[23:4] == `PCE_HDR_BANK0_ADDR) || (a[23:4] == `PCE_HDR_BANK1_ADDR)) begin
				if ((off >= 6) && (off <= 12) && sig_mask[a[13]]) begin
					raw = swap ? reverse16(sig_word((off - 6) / 2)) : sig_word((off - 6) / 2);
					if (bad && a[13] && (off == 10))
						raw = raw ^ 16'h0100;
				end
				exp_data = swap ? reverse16(raw) : raw;
				if ((off >= 6) && (off <= 12) && (exp_data != sig_word((off - 6) / 2)))
					pop_exp[a[13]] = 1'b0;
			end
			send_rom_word(a, raw, swap);
		end
		ioctl.download = 1'b0;
		repeat (2) @(negedge clk_sys);
		check("populous", 32'(pop_exp), 32'(populous));
		check("sgx", 32'(index[4:0] == `PCE_SGX_INDEX), 32'(sgx));
	endtask

	task automatic write_byte(input logic [10:0] addr, input logic [7:0] data);
		logic [11:0] w;
		w = {2'b00, addr[10:1]};
		lane_mem[addr[0]][w] = data;
		known[addr[0]][w] = 1'b1;
		bram_addr = addr;
		bram_data = data;
		bram_wr = 1'b1;
		@(negedge clk_sys);
		bram_wr = 1'b0;
	endtask

	task automatic read_byte(input logic [10:0] addr);
		logic [11:0] w;
		w = {2'b00, addr[10:1]};
		bram_addr = addr;
		@(negedge clk_sys);   // Data one cycle after the address
		if (known[addr[0]][w])
			check("bram_q", 32'(lane_mem[addr[0]][w]), 32'(bram_q));
	endtask

	// SD host model serving all sectors of one load or save
	task automatic serve_transfer(input logic loading);
		logic [11:0] w;
		for (int s = 0; s < `PCE_BRAM_SECTORS; s++) begin
			while (!(sd_rd || sd_wr))
				@(negedge clk_sys);
			check("sd_lba", s, sd_lba);
			check("sd_rd", 32'(loading), 32'(sd_rd));
			check("sd_wr", 32'(!loading), 32'(sd_wr));
			check("bk_busy", 32'(1), 32'(bk_busy));
			repeat (int'($unsigned($random(seed)) % 4)) @(negedge clk_sys);
			sd.ack = 1'b1;
			if (loading) begin
				for (int k = 0; k < `PCE_SECTOR_WORDS; k++) begin
					w = {4'(s), 8'(k)};
					sd.buff_addr = 8'(k);
					sd.buff_dout = 16'($random(seed));
					sd.buff_wr = 1'b1;
					lane_mem[0][w] = sd.buff_dout[7:0];
					lane_mem[1][w] = sd.buff_dout[15:8];
					known[0][w] = 1'b1;
					known[1][w] = 1'b1;
					@(negedge clk_sys);
				end
				sd.buff_wr = 1'b0;
			end else begin
				for (int k = 0; k < `PCE_SECTOR_WORDS; k++) begin
					sd.buff_addr = 8'(k);
					@(negedge clk_sys);   // Buffer data one cycle after the address
					w = {4'(s), 8'(k)};
					if (known[0][w] && known[1][w])
						check("sd_buff_din", 32'({lane_mem[1][w], lane_mem[0][w]}),
							32'(sd_buff_din));
				end
			end
			sd.ack = 1'b0;
			@(negedge clk_sys);
		end
		while (bk_busy)
			@(negedge clk_sys);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin : main
		logic [15:0] w [8];
		reset = 1'b1;
		ioctl = '0;
		menu = '0;
		rom_wr_ack = 1'b0;
		bram_addr = '0;
		bram_data = '0;
		bram_wr = 1'b0;
		sd = '0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_present = 1'b0;
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		load_image({3'b000, 5'($random(seed))}, 300, 2'b00, 1'b0);
		load_image(8'h02, IMAGE_WORDS, 2'b01, 1'b0);   // Bank 0 only
		load_image(8'h41, IMAGE_WORDS, 2'b11, 1'b0);
		load_image(8'h22, IMAGE_WORDS, 2'b11, 1'b1);   // One word wrong

		// Cheat record
		ioctl.index = 8'hff;
		ioctl.download = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < 8; i++) begin
			w[i] = 16'($random(seed));
			ioctl.addr = 25'(2 * i);
			ioctl.data = w[i];
			ioctl.wr = 1'b1;
			@(negedge clk_sys);
			ioctl.wr = 1'b0;
			if (i < 7)
				check("cheat load early", 32'(0), 32'(cheat.load));
		end
		check("cheat load", 32'(1), 32'(cheat.load));
		check("cheat flags", {w[1], w[0]}, cheat.flags);
		check("cheat addr", {w[3], w[2]}, cheat.addr);
		check("cheat compare", {w[5], w[4]}, cheat.compare);
		check("cheat replace", {w[7], w[6]}, cheat.replace);
		@(negedge clk_sys);
		check("cheat load width", 32'(0), 32'(cheat.load));
		ioctl.download = 1'b0;
		@(negedge clk_sys);

		// Console port
		for (int a = 0; a < 2048; a++)
			write_byte(11'(a), 8'($random(seed)));
		for (int n = 0; n < 600; n++) begin
			if (1'($random(seed)))
				write_byte(11'($random(seed)), 8'($random(seed)));
			else
				read_byte(11'($random(seed)));
		end

		// Format
		menu.format = 1'b1;
		repeat (10) @(negedge clk_sys);
		menu.format = 1'b0;
		for (int k = 0; k < 4; k++) begin
			lane_mem[0][k] = 8'(fmt_word(k));
			lane_mem[1][k] = 8'(fmt_word(k) >> 8);
		end
		for (int a = 0; a < 8; a++)
			read_byte(11'(a));

		// Enable backup with a writable image
		ioctl.index = 8'h00;
		ioctl.download = 1'b1;
		repeat (2) @(negedge clk_sys);
		img_mounted = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		ioctl.download = 1'b0;
		repeat (2) @(negedge clk_sys);

		menu.bk_save = 1'b1;
		serve_transfer(1'b0);
		menu.bk_save = 1'b0;
		@(negedge clk_sys);

		menu.bk_load = 1'b1;
		@(negedge clk_sys);
		check("bk_loading", 32'(1), 32'(bk_loading));
		serve_transfer(1'b1);
		menu.bk_load = 1'b0;
		for (int n = 0; n < 300; n++)
			read_byte(11'($random(seed)));

		// Autosave
		write_byte(11'($random(seed)), 8'($random(seed)));
		check("bk_pending set", 32'(1), 32'(bk_pending));
		menu.autosave = 1'b1;
		menu.osd_open = 1'b1;
		serve_transfer(1'b0);
		check("bk_pending clear", 32'(0), 32'(bk_pending));
		menu.autosave = 1'b0;
		menu.osd_open = 1'b0;
		@(negedge clk_sys);

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* pce_media_top.f */
+incdir+common
common/pce_media_pkg.sv
source/cart_loader.sv
source/cheat_code_assembler.sv
backup/backup_ram.sv
backup/backup_sector_ctrl.sv
source/pce_media_top.sv
verif/tb_pce_media_top.sv

/* Makefile */
# Verilator build and run of the pce_media_top testbench

BIN  := obj_dir/Vtb_pce_media_top
SRCS := $(wildcard common/*.sv common/*.svh source/*.sv backup/*.sv verif/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) pce_media_top.f
	verilator --binary --timing -j 0 --top-module tb_pce_media_top -f pce_media_top.f

# Pass only when the testbench printed its pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
